/* hdl/fetch_pkg.sv */
`default_nettype none

// Shared definitions for the fetch stage
package fetch_pkg;

  // Instruction, address and memory data width
  localparam int WORD_WIDTH = 32;

  // Unconditional relative jump opcode
  localparam logic [6:0] OPC_JUMP = 7'b110_1111;

  // First fetch address after reset, word aligned
  localparam logic [WORD_WIDTH-1:0] RESET_PC = 32'h0000_0040;

  // One instruction word seen in two formats
  // Opcode sits in the top seven bits of both views
  typedef union packed {
    // Register to register format
    struct packed {
      logic [6:0] opcode;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [9:0] funct;
    } alu_fmt;
    // Relative jump, offset counted in words
    struct packed {
      logic [6:0]         opcode;
      logic signed [24:0] offset;
    } jump_fmt;
  } fetch_word_u;

endpackage

`default_nettype wire

/* hdl/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic hit,
  input  logic stall,
  input  logic mem_valid,
  output logic advance,
  output logic fill_req,
  output logic fill_done
);

  // State encodings
  localparam logic [1:0] LOOKUP    = 2'd0;
  localparam logic [1:0] REQUEST   = 2'd1;
  localparam logic [1:0] WAIT_FILL = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;

  // Next state logic
  always_comb
  begin
    state_next = state;
    case (state)
      LOOKUP:
      begin
        // Miss only starts a fill when the stage is not frozen
        if (!hit && !stall)
        begin
          state_next = REQUEST;
        end
      end
      REQUEST:
      begin
        // Request lives for exactly one cycle
        state_next = WAIT_FILL;
      end
      WAIT_FILL:
      begin
        // Fill completes even under stall
        if (mem_valid)
        begin
          state_next = LOOKUP;
        end
      end
      default:
      begin
        state_next = LOOKUP;
      end
    endcase
  end

  // State register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= LOOKUP;
    end
    else
    begin
      state <= state_next;
    end
  end

  // Move on only with a hit and no hazard
  assign advance = (state == LOOKUP) && hit && !stall;

  // Single cycle strobe toward memory
  assign fill_req = (state == REQUEST);

  // Line write strobe for the cache
  assign fill_done = (state == WAIT_FILL) && mem_valid;

endmodule

`default_nettype wire

/* hdl/pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           advance,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] word,
  output logic [fetch_pkg::WORD_WIDTH-1:0] pc
);

  import fetch_pkg::*;

  fetch_word_u            decoded;
  logic                   is_jump;
  logic [WORD_WIDTH-1:0]  jump_step;
  logic [WORD_WIDTH-1:0]  pc_next;

  // Predecode the word just fetched
  assign decoded = word;
  assign is_jump = (decoded.jump_fmt.opcode == OPC_JUMP);

  // Sign extend the word offset and scale to bytes
  assign jump_step = {{(WORD_WIDTH-27){decoded.jump_fmt.offset[24]}},
                      decoded.jump_fmt.offset, 2'b00};

  // Jump redirect or plain sequential step
  assign pc_next = is_jump ? (pc + jump_step) : (pc + 32'd4);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc <= RESET_PC;
    end
    else if (advance)
    begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
  parameter int LINES = 8
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] pc,
  input  logic                           fill_done,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] mem_data,
  output logic                           hit,
  output logic [fetch_pkg::WORD_WIDTH-1:0] hit_word
);

  import fetch_pkg::*;

  // Address split, byte offset then index then tag
  // LINES is a power of two, at least two
  localparam int OFFSET_BITS = 2;
  localparam int INDEX_BITS  = $clog2(LINES);
  localparam int TAG_BITS    = WORD_WIDTH - INDEX_BITS - OFFSET_BITS;

  // One word per line
  logic [WORD_WIDTH-1:0] data_array [LINES];
  logic [TAG_BITS-1:0]   tag_array  [LINES];
  logic [LINES-1:0]      valid_bits;

  logic [INDEX_BITS-1:0] index;
  logic [TAG_BITS-1:0]   tag;

  // Word address bits pick the line
  assign index = pc[OFFSET_BITS +: INDEX_BITS];

  // Remaining upper bits identify the word
  assign tag = pc[WORD_WIDTH-1 -: TAG_BITS];

  // Combinational lookup
  assign hit      = valid_bits[index] && (tag_array[index] == tag);
  assign hit_word = data_array[index];

  // Valid bits, cleared so nothing hits after reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_bits <= '0;
    end
    else if (fill_done)
    begin
      valid_bits[index] <= 1'b1;
    end
  end

  // Data and tag storage
  // pc holds still for the whole fill, so index and tag match the request
  always_ff @(posedge clk)
  begin
    if (fill_done)
    begin
      data_array[index] <= mem_data;
      tag_array[index]  <= tag;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_registers (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           advance,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] pc,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] instruction_in,
  output logic [fetch_pkg::WORD_WIDTH-1:0] instruction_out,
  output logic [fetch_pkg::WORD_WIDTH-1:0] rm0_out,
  output logic                           active_out
);

  // Instruction and its address toward decode
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      instruction_out <= '0;
      rm0_out         <= '0;
    end
    else if (advance)
    begin
      instruction_out <= instruction_in;
      rm0_out         <= pc;
    end
  end

  // High only in the cycle after a capture
  // Held outputs stay put while this is low
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active_out <= 1'b0;
    end
    else
    begin
      active_out <= advance;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter int LINES = 8
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           stall,
  input  logic                           mem_valid,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] mem_data,
  output logic                           mem_req,
  output logic [fetch_pkg::WORD_WIDTH-1:0] mem_addr,
  output logic [fetch_pkg::WORD_WIDTH-1:0] instruction_out,
  output logic [fetch_pkg::WORD_WIDTH-1:0] rm0_out,
  output logic                           active_out
);

  import fetch_pkg::*;

  // Internal nets
  logic [WORD_WIDTH-1:0] pc;
  logic [WORD_WIDTH-1:0] hit_word;
  logic                  hit;
  logic                  advance;
  logic                  fill_done;

  // Miss fetches the word at the current pc
  assign mem_addr = pc;

  // Sequencing of lookup, fill and stall
  fetch_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .hit       (hit),
    .stall     (stall),
    .mem_valid (mem_valid),
    .advance   (advance),
    .fill_req  (mem_req),
    .fill_done (fill_done)
  );

  // Next address, predecodes the hit word for jumps
  pc_counter u_pc (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .word    (hit_word),
    .pc      (pc)
  );

  icache #(
    .LINES (LINES)
  ) u_icache (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .fill_done (fill_done),
    .mem_data  (mem_data),
    .hit       (hit),
    .hit_word  (hit_word)
  );

  // Hand off to decode
  fetch_registers u_regs (
    .clk             (clk),
    .rst             (rst),
    .advance         (advance),
    .pc              (pc),
    .instruction_in  (hit_word),
    .instruction_out (instruction_out),
    .rm0_out         (rm0_out),
    .active_out      (active_out)
  );

endmodule

`default_nettype wire

/* verif/fetch_unit_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_assert (
  input logic clk,
  input logic rst,
  input logic mem_req,
  input logic mem_valid,
  input logic stall,
  input logic active_out
);

  // Tracks a request still waiting for its answer
  logic outstanding;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outstanding <= 1'b0;
    end
    else if (mem_req)
    begin
      outstanding <= 1'b1;
    end
    else if (mem_valid)
    begin
      outstanding <= 1'b0;
    end
  end

  // Request strobe is a single cycle
  req_single_cycle: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
    else $error("mem_req stayed high for two cycles");

  // One fill at a time
  req_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    mem_req |-> !outstanding)
    else $error("new mem_req issued before mem_valid");

  // Frozen stage delivers nothing
  no_active_after_stall: assert property (@(posedge clk) disable iff (rst)
    stall |=> !active_out)
    else $error("active_out high in the cycle after stall");

endmodule

bind fetch_unit fetch_unit_assert u_assert (
  .clk        (clk),
  .rst        (rst),
  .mem_req    (mem_req),
  .mem_valid  (mem_valid),
  .stall      (stall),
  .active_out (active_out)
);

`default_nettype wire

/* verif/fetch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker #(
  parameter int LINES = 8
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             stall,
  input  logic                             mem_req,
  input  logic                             mem_valid,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] mem_addr,
  input  logic                             active_out,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] instruction_out,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] rm0_out,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] ref_word,
  output int                               error_count,
  output int                               delivered_count
);

  import fetch_pkg::*;

  // Cache model, whole address per line
  logic [WORD_WIDTH-1:0] model_addr [LINES];
  logic                  model_valid [LINES];

  logic [WORD_WIDTH-1:0] exp_pc;
  logic [WORD_WIDTH-1:0] fill_addr;
  logic [WORD_WIDTH-1:0] pend_addr;
  logic                  outstanding;
  logic                  pending;
  logic                  stall_q;
  logic                  post_reset;
  int                    line;

  initial
  begin
    error_count     = 0;
    delivered_count = 0;
  end

  // One word per line, word address modulo line count
  function automatic int line_of(input logic [WORD_WIDTH-1:0] addr);
    return int'((addr >> 2) % LINES);
  endfunction

  function automatic logic present(input logic [WORD_WIDTH-1:0] addr);
    int l;
    l = line_of(addr);
    return model_valid[l] && (model_addr[l] == addr);
  endfunction

  // Jumps move by a signed word offset, everything else by one word
  function automatic logic [WORD_WIDTH-1:0] next_pc(input logic [WORD_WIDTH-1:0] addr,
                                                    input logic [WORD_WIDTH-1:0] word);
    fetch_word_u        w;
    logic signed [31:0] step;
    w = word;
    if (w.jump_fmt.opcode == OPC_JUMP)
    begin
      step = 32'(w.jump_fmt.offset);
      return addr + (step <<< 2);
    end
    return addr + 32'd4;
  endfunction

  task automatic flag_error(input string msg);
    error_count++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  // Sample at the rising edge, inputs change on the falling edge
  always @(posedge clk)
  begin
    if (rst)
    begin
      exp_pc      = RESET_PC;
      outstanding = 1'b0;
      pending     = 1'b0;
      stall_q     = 1'b0;
      post_reset  = 1'b1;
      for (int i = 0; i < LINES; i++)
      begin
        model_valid[i] = 1'b0;
      end
    end
    else
    begin
      if (post_reset && (active_out || mem_req))
      begin
        flag_error("active_out or mem_req high right after reset");
      end
      post_reset = 1'b0;
      if (mem_req)
      begin
        if (outstanding)
          flag_error("mem_req while a fill is still outstanding");
        if (mem_addr != exp_pc)
          flag_error($sformatf("mem_addr %h, expected %h", mem_addr, exp_pc));
        if (present(mem_addr))
          flag_error($sformatf("mem_req for address %h already cached", mem_addr));
        outstanding = 1'b1;
        fill_addr   = mem_addr;
      end
      if (active_out)
      begin
        if (stall_q)
          flag_error("instruction delivered in the cycle after stall");
        if (rm0_out != exp_pc)
          flag_error($sformatf("rm0_out %h, expected %h", rm0_out, exp_pc));
        if (!present(rm0_out))
          flag_error($sformatf("address %h delivered without a fill", rm0_out));
        if (instruction_out != ref_word)
          flag_error($sformatf("instruction_out %h at %h, expected %h",
                               instruction_out, rm0_out, ref_word));
        if (pending && (pend_addr != rm0_out))
          flag_error($sformatf("fill of %h followed by delivery of %h", pend_addr, rm0_out));
        pending = 1'b0;
        delivered_count++;
        // Next expected address follows the delivered word
        exp_pc = next_pc(rm0_out, ref_word);
      end
      if (mem_valid)
      begin
        if (!outstanding)
        begin
          flag_error("mem_valid without a request");
        end
        else
        begin
          line              = line_of(fill_addr);
          model_valid[line] = 1'b1;
          model_addr[line]  = fill_addr;
          outstanding       = 1'b0;
          pending           = 1'b1;
          pend_addr         = fill_addr;
        end
      end
      stall_q = stall;
    end
  end

endmodule

`default_nettype wire

/* verif/fetch_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;

  import fetch_pkg::*;

  localparam int TARGET    = 400;
  localparam int RUN_LIMIT = 20000;
  localparam int REQ_LIMIT = 100;

  logic                  clk;
  logic                  rst;
  logic                  stall;
  logic                  mem_valid;
  logic                  mem_req;
  logic                  active_out;
  logic                  done;
  logic [WORD_WIDTH-1:0] mem_data;
  logic [WORD_WIDTH-1:0] mem_addr;
  logic [WORD_WIDTH-1:0] instruction_out;
  logic [WORD_WIDTH-1:0] rm0_out;
  logic [WORD_WIDTH-1:0] ref_word;
  int                    seed;
  int                    tb_errors;
  int                    error_count;
  int                    delivered_count;

  // Program image
  // Every fifth word jumps, every twentieth jumps back into a loop
  function automatic logic [WORD_WIDTH-1:0] mem_word(input logic [WORD_WIDTH-1:0] addr);
    fetch_word_u w;
    logic [29:0] idx;
    idx = addr[31:2];
    if (idx % 5 == 0)
    begin
      w.jump_fmt.opcode = OPC_JUMP;
      if (idx % 20 == 0)
        w.jump_fmt.offset = -25'sd13;
      else
        w.jump_fmt.offset = 25'sd2;
    end
    else
    begin
      w.alu_fmt.opcode = 7'b011_0011;
      w.alu_fmt.rd     = idx[4:0];
      w.alu_fmt.rs1    = idx[9:5] ^ idx[4:0];
      w.alu_fmt.rs2    = ~idx[4:0];
      // Folds every word address bit into the word
      w.alu_fmt.funct  = idx[9:0] ^ idx[19:10] ^ idx[29:20] ^ 10'h16b;
    end
    return w;
  endfunction

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Expected word for whatever address is on the output
  assign ref_word = mem_word(rm0_out);

  fetch_unit #(.LINES(8)) u_dut (
    .clk(clk), .rst(rst), .stall(stall), .mem_valid(mem_valid), .mem_data(mem_data),
    .mem_req(mem_req), .mem_addr(mem_addr), .instruction_out(instruction_out),
    .rm0_out(rm0_out), .active_out(active_out)
  );

  fetch_checker #(.LINES(8)) u_chk (
    .clk(clk), .rst(rst), .stall(stall), .mem_req(mem_req), .mem_valid(mem_valid),
    .mem_addr(mem_addr), .active_out(active_out), .instruction_out(instruction_out),
    .rm0_out(rm0_out), .ref_word(ref_word), .error_count(error_count),
    .delivered_count(delivered_count)
  );

  task automatic wait_reset_release(input string who);
    int n;
    n = 0;
    // Look only after the first falling edge, when reset is already driven
    @(negedge clk);
    while (rst && n < 40)
    begin
      @(negedge clk);
      n++;
    end
    if (rst)
    begin
      $display("%s: reset was never released", who);
      tb_errors++;
    end
  endtask

  // Memory answers each request after 1 to 6 cycles
  initial
  begin : memory_model
    int                    delay;
    int                    waited;
    logic [WORD_WIDTH-1:0] addr;
    wait_reset_release("memory model");
    while (!done)
    begin
      waited = 0;
      while (!mem_req && !done && waited < REQ_LIMIT)
      begin
        @(negedge clk);
        waited++;
      end
      if (done)
        break;
      if (!mem_req)
      begin
        $display("Memory model timed out waiting for a fetch request");
        tb_errors++;
        break;
      end
      addr  = mem_addr;
      delay = int'($unsigned($random(seed)) % 6) + 1;
      repeat (delay) @(negedge clk);
      mem_valid = 1'b1;
      mem_data  = mem_word(addr);
      @(negedge clk);
      mem_valid = 1'b0;
    end
  end

  // Stall bursts of 1 to 4 cycles with random gaps, fills included
  initial
  begin : stall_gen
    int gap;
    int burst;
    wait_reset_release("stall generator");
    while (!done)
    begin
      gap = int'($unsigned($random(seed)) % 8);
      repeat (gap) @(negedge clk);
      burst = int'($unsigned($random(seed)) % 4) + 1;
      stall = 1'b1;
      repeat (burst) @(negedge clk);
      stall = 1'b0;
      @(negedge clk);
    end
  end

  initial
  begin : main
    int cycles;
    seed      = 32'h1add_99d2;
    rst       = 1'b1;
    stall     = 1'b0;
    mem_valid = 1'b0;
    mem_data  = '0;
    done      = 1'b0;
    tb_errors = 0;
    cycles    = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (delivered_count < TARGET && tb_errors == 0 && cycles < RUN_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (delivered_count < TARGET && tb_errors == 0)
    begin
      $display("Timed out waiting for %0d deliveries, got %0d", TARGET, delivered_count);
      tb_errors++;
    end
    done = 1'b1;
    repeat (2) @(negedge clk);
    $display("deliveries=%0d checker_errors=%0d tb_errors=%0d",
             delivered_count, error_count, tb_errors);
    if (error_count == 0 && tb_errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* fetch_unit.f */
hdl/fetch_pkg.sv
hdl/fetch_ctrl.sv
hdl/pc_counter.sv
hdl/icache.sv
hdl/fetch_registers.sv
hdl/fetch_unit.sv
verif/fetch_unit_assert.sv
verif/fetch_checker.sv
verif/fetch_unit_tb.sv

/* Makefile */
# Verilator build for the fetch stage testbench
VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FLIST     ?= fetch_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The log decides the result, the simulator exit code alone is not enough
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^sim passed$$" $(LOG); then \
	  echo "Result: PASS"; \
	else \
	  echo "Result: FAIL"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
